// File: include/sine_quarter.svh
// quarter-wave sine table, first quadrant only
// 11-bit magnitudes; the sign comes from phase bit 31
// entry i sits at the middle of its step (i + 0.5)
// so the mirrored half reuses the same entries without an offset
// peak is 2047, matching AMPLITUDE

localparam logic [10:0] SINE_QUARTER [0:63] = '{
   11'd25,   11'd75,   11'd126,  11'd176,   // 0..3
   11'd226,  11'd275,  11'd325,  11'd375,
   11'd424,  11'd473,  11'd522,  11'd570,
   11'd618,  11'd666,  11'd713,  11'd760,
   11'd806,  11'd852,  11'd898,  11'd943,   // 16..19
   11'd987,  11'd1031, 11'd1074, 11'd1116,
   11'd1158, 11'd1199, 11'd1239, 11'd1279,
   11'd1318, 11'd1356, 11'd1393, 11'd1430,
   11'd1465, 11'd1500, 11'd1533, 11'd1566,  // 32..35
   11'd1598, 11'd1629, 11'd1659, 11'd1688,
   11'd1716, 11'd1743, 11'd1769, 11'd1793,
   11'd1817, 11'd1840, 11'd1861, 11'd1881,
   11'd1901, 11'd1919, 11'd1936, 11'd1951,  // 48..51
   11'd1966, 11'd1979, 11'd1992, 11'd2003,
   11'd2012, 11'd2021, 11'd2028, 11'd2035,
   11'd2039, 11'd2043, 11'd2046, 11'd2047   // top of the quarter
};

// File: verilog/dds_pkg.sv
`default_nettype none

package dds_pkg;

   ////////////////////////////////////////////////////////////
   // widths and data types
   ////////////////////////////////////////////////////////////

   localparam int SAMPLE_W = 12;
   typedef logic signed [SAMPLE_W-1:0] sample_t;   // two's complement sample

   localparam int PHASE_W = 32;
   typedef logic [PHASE_W-1:0] phase_t;

   localparam int LFSR_W = 5;
   typedef logic [LFSR_W-1:0] lfsr_t;

   localparam lfsr_t   LFSR_SEED          = 5'd1;
   localparam int      LFSR_DIV_DEFAULT   = 25_000_000;   // one step per second
   localparam sample_t AMPLITUDE          = 12'sd2047;
   localparam sample_t ASK_OFF_LEVEL      = 12'sd0;
   localparam sample_t LFSR_DISPLAY_LEVEL = 12'sh800;     // most negative code

   localparam int KEY_COUNT = 17;
   localparam int KEY_IDX_W = $clog2(KEY_COUNT);

   ////////////////////////////////////////////////////////////
   // opcodes
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {WAVE_SIN, WAVE_COS, WAVE_SAW, WAVE_SQU} wave_sel_e;

   typedef enum logic [1:0] {MOD_ASK, MOD_BPSK, MOD_LFSR, MOD_NONE} mod_sel_e;

   // make code = key bit index, break code = index + 128
   typedef enum logic [7:0] {
      KEY_MAKE_DOWN   = 8'd0,  KEY_MAKE_UP,    KEY_MAKE_RIGHT, KEY_MAKE_LEFT,
      KEY_MAKE_SPACE,          KEY_MAKE_M,     KEY_MAKE_N,     KEY_MAKE_F2,
      KEY_MAKE_F1,             KEY_MAKE_K8,    KEY_MAKE_K7,    KEY_MAKE_K6,
      KEY_MAKE_K5,             KEY_MAKE_K4,    KEY_MAKE_K3,    KEY_MAKE_K2,
      KEY_MAKE_K1,
      KEY_BREAK_DOWN  = 8'd128, KEY_BREAK_UP,  KEY_BREAK_RIGHT, KEY_BREAK_LEFT,
      KEY_BREAK_SPACE,          KEY_BREAK_M,   KEY_BREAK_N,     KEY_BREAK_F2,
      KEY_BREAK_F1,             KEY_BREAK_K8,  KEY_BREAK_K7,    KEY_BREAK_K6,
      KEY_BREAK_K5,             KEY_BREAK_K4,  KEY_BREAK_K3,    KEY_BREAK_K2,
      KEY_BREAK_K1
   } key_event_e;

   ////////////////////////////////////////////////////////////
   // grouped signals
   ////////////////////////////////////////////////////////////

   // held-key bitmap, down is bit 0
   typedef struct packed {
      logic k1;
      logic k2;
      logic k3;
      logic k4;
      logic k5;
      logic k6;
      logic k7;
      logic k8;
      logic f1;
      logic f2;
      logic n;
      logic m;
      logic space;
      logic left;
      logic right;
      logic up;
      logic down;
   } key_hold_t;

   typedef struct packed {
      sample_t sin;
      sample_t cos;
      sample_t saw;
      sample_t squ;
   } wave_set_t;

endpackage

`default_nettype wire

// File: verilog/dds_control.sv
`default_nettype none

module dds_control #(
   parameter int lfsr_div = dds_pkg::LFSR_DIV_DEFAULT
) (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_pkg::key_event_e   key_event,
   input  logic                  key_event_ready,
   output dds_pkg::key_hold_t    held_keys,
   output logic                  lfsr_step
);

   import dds_pkg::*;

   localparam int DIV_W = (lfsr_div > 1) ? $clog2(lfsr_div) : 1;
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(lfsr_div - 1);

   logic                 is_make;
   logic                 is_break;
   logic [KEY_COUNT-1:0] key_mask;
   logic [DIV_W-1:0]     div_count;

   ////////////////////////////////////////////////////////////
   // key event decode
   ////////////////////////////////////////////////////////////

   // make codes start at 0, so only the top bound matters
   assign is_make  = key_event_ready && (key_event <= KEY_MAKE_K1);
   assign is_break = key_event_ready && (key_event >= KEY_BREAK_DOWN)
                     && (key_event <= KEY_BREAK_K1);

   // low bits give the key index for both make and break
   assign key_mask = KEY_COUNT'(1) << key_event[KEY_IDX_W-1:0];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
      end
      else if (is_make)
      begin
         held_keys <= held_keys | key_mask;   // key pressed
      end
      else if (is_break)
      begin
         held_keys <= held_keys & ~key_mask;  // key released
      end
   end

   ////////////////////////////////////////////////////////////
   // LFSR step tick
   ////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         div_count <= '0;
      end
      else if (div_count == DIV_LAST)
      begin
         div_count <= '0;  // wrap
      end
      else
      begin
         div_count <= div_count + 1'b1;
      end
   end

   // one cycle wide, every lfsr_div cycles
   assign lfsr_step = (div_count == DIV_LAST);

endmodule

`default_nettype wire

// File: verilog/dds_core.sv
`default_nettype none

module dds_core (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  dds_pkg::phase_t     phase_inc,
   output dds_pkg::wave_set_t  waves
);

   import dds_pkg::*;

   `include "sine_quarter.svh"

   localparam int     ADDR_W       = 6;
   localparam phase_t QUARTER_TURN = phase_t'(1) << (PHASE_W - 2);

   phase_t phase_acc;

   // full-wave sine from the quarter table
   // bit 31 picks the half, bit 30 the mirrored quarter
   function automatic sample_t wave_lookup(input phase_t ph);
      logic [ADDR_W-1:0] addr;
      sample_t           mag;
      addr = ph[PHASE_W-3 -: ADDR_W];
      if (ph[PHASE_W-2])
      begin
         addr = ~addr;  // falling quarter
      end
      mag = sample_t'({1'b0, SINE_QUARTER[addr]});
      return ph[PHASE_W-1] ? -mag : mag;
   endfunction

   ////////////////////////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase_acc <= '0;
      end
      else
      begin
         phase_acc <= phase_acc + phase_inc;  // wraps mod 2^32
      end
   end

   ////////////////////////////////////////////////////////////
   // waveforms, one cycle behind the accumulator
   ////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      waves.sin <= wave_lookup(phase_acc);
      waves.cos <= wave_lookup(phase_acc + QUARTER_TURN);
      // top phase bits read as signed give the ramp
      waves.saw <= sample_t'(phase_acc[PHASE_W-1 -: SAMPLE_W]);
      waves.squ <= phase_acc[PHASE_W-1] ? -AMPLITUDE : AMPLITUDE;
   end

endmodule

`default_nettype wire

// File: verilog/lfsr_gen.sv
`default_nettype none

module lfsr_gen (
   input  logic            CLK_25MHZ,
   input  logic            reset_from_key,
   input  logic            lfsr_step,
   output dds_pkg::lfsr_t  lfsr_q
);

   import dds_pkg::*;

   logic feedback;

   // taps for x^5 + x^3 + 1, period 31
   assign feedback = lfsr_q[4] ^ lfsr_q[2];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr_q <= LFSR_SEED;
      end
      else if (lfsr_step)
      begin
         lfsr_q <= {lfsr_q[LFSR_W-2:0], feedback};  // shift left, new bit at 0
      end
   end

endmodule

`default_nettype wire

// File: verilog/modulator.sv
`default_nettype none

module modulator (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  dds_pkg::wave_set_t  waves,
   input  dds_pkg::wave_sel_e  wave_sel,
   input  dds_pkg::mod_sel_e   mod_sel,
   input  dds_pkg::lfsr_t      lfsr_q,
   output dds_pkg::sample_t    signal_out,
   output dds_pkg::sample_t    modulated_out
);

   import dds_pkg::*;

   logic    key_bit;
   sample_t carrier;
   sample_t mod_next;

   assign key_bit = lfsr_q[0];

   // carrier select
   always_comb
   begin
      case (wave_sel)
         WAVE_COS: carrier = waves.cos;
         WAVE_SAW: carrier = waves.saw;
         WAVE_SQU: carrier = waves.squ;
         default:  carrier = waves.sin;
      endcase
   end

   // modulation, all keyed by the same LFSR bit
   always_comb
   begin
      case (mod_sel)
         MOD_ASK:  mod_next = key_bit ? carrier : ASK_OFF_LEVEL;
         MOD_BPSK: mod_next = key_bit ? -carrier : carrier;  // 180 degree flip
         MOD_LFSR: mod_next = key_bit ? LFSR_DISPLAY_LEVEL : '0;
         default:  mod_next = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // output registers, sampled on the same edge
   ////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         signal_out    <= '0;
         modulated_out <= '0;
      end
      else
      begin
         signal_out    <= carrier;
         modulated_out <= mod_next;
      end
   end

endmodule

`default_nettype wire

// File: verilog/dds_lfsr_top.sv
`default_nettype none

module dds_lfsr_top #(
   parameter int lfsr_div = dds_pkg::LFSR_DIV_DEFAULT
) (
   input  logic                 CLK_25MHZ,
   input  logic                 reset_from_key,
   input  dds_pkg::key_event_e  key_event,
   input  logic                 key_event_ready,
   input  dds_pkg::wave_sel_e   wave_sel,
   input  dds_pkg::mod_sel_e    mod_sel,
   input  dds_pkg::phase_t      phase_inc,
   output dds_pkg::key_hold_t   held_keys,
   output dds_pkg::sample_t     signal_out,
   output dds_pkg::sample_t     modulated_out,
   output dds_pkg::lfsr_t       lfsr_state
);

   import dds_pkg::*;

   logic      lfsr_step;  // one pulse per LFSR step
   wave_set_t waves;

   ////////////////////////////////////////////////////////////
   // control: key tracking and step tick
   ////////////////////////////////////////////////////////////

   dds_control #(
      .lfsr_div        (lfsr_div)
   ) u_control (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event       (key_event),
      .key_event_ready (key_event_ready),
      .held_keys       (held_keys),
      .lfsr_step       (lfsr_step)
   );

   ////////////////////////////////////////////////////////////
   // signal path
   ////////////////////////////////////////////////////////////

   dds_core u_core (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .phase_inc       (phase_inc),
      .waves           (waves)
   );

   lfsr_gen u_lfsr (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .lfsr_step       (lfsr_step),
      .lfsr_q          (lfsr_state)      // also keys the modulator
   );

   modulator u_mod (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .waves           (waves),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .lfsr_q          (lfsr_state),
      .signal_out      (signal_out),
      .modulated_out   (modulated_out)
   );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 8
) (
   output logic CLK_25MHZ,
   output logic reset_from_key
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #(period_ns / 2) CLK_25MHZ = ~CLK_25MHZ;
   end

   initial
   begin
      reset_from_key = 1'b1;
      repeat (reset_cycles) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;  // released on a rising edge
   end

endmodule

`default_nettype wire

// File: tb/dds_lfsr_assert.sv
`default_nettype none

module dds_lfsr_assert (
   input logic                CLK_25MHZ,
   input logic                reset_from_key,
   input dds_pkg::mod_sel_e   mod_sel,
   input dds_pkg::key_hold_t  held_keys,
   input dds_pkg::sample_t    signal_out,
   input dds_pkg::sample_t    modulated_out,
   input dds_pkg::lfsr_t      lfsr_state
);

   timeunit 1ns;
   timeprecision 100ps;

   import dds_pkg::*;

   // registers take their reset values on the edge that sees reset
   reset_clears_outputs: assert property (@(posedge CLK_25MHZ)
      reset_from_key |=> (signal_out == '0 && modulated_out == '0 && held_keys == '0))
      else $error("outputs not zero during reset");

   // the all-zero state would lock the LFSR up
   lfsr_never_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state != '0)
      else $error("lfsr_state reached zero");

   mod_none_is_zero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      mod_sel == MOD_NONE |=> modulated_out == '0)
      else $error("modulated_out not zero one cycle after MOD_NONE");

endmodule

bind dds_lfsr_top dds_lfsr_assert u_assert (
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .mod_sel        (mod_sel),
   .held_keys      (held_keys),
   .signal_out     (signal_out),
   .modulated_out  (modulated_out),
   .lfsr_state     (lfsr_state)
);

`default_nettype wire

// File: tb/dds_lfsr_tb.sv
`default_nettype none

module dds_lfsr_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import dds_pkg::*;

   `include "sine_quarter.svh"

   localparam int     SAMPLE_RUN   = 64;
   localparam int     WAIT_LIMIT   = 200;   // cycles per wait loop
   localparam phase_t QUARTER_TURN = 32'h4000_0000;

   logic       CLK_25MHZ;
   logic       reset_from_key;
   key_event_e key_event;
   logic       key_event_ready;
   wave_sel_e  wave_sel;
   mod_sel_e   mod_sel;
   phase_t     phase_inc;
   key_hold_t  held_keys;
   sample_t    signal_out;
   sample_t    modulated_out;
   lfsr_t      lfsr_state;

   phase_t acc_model;
   phase_t phase_d1;   // phase behind the waves register
   phase_t phase_d2;   // phase behind signal_out
   int     check_errors;
   int     timeout_errors;
   int     waited;

   tb_clock_gen #(.period_ns(40), .reset_cycles(8)) u_clock (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key)
   );

   dds_lfsr_top #(.lfsr_div(16)) dut0 (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event       (key_event),
      .key_event_ready (key_event_ready),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .phase_inc       (phase_inc),
      .held_keys       (held_keys),
      .signal_out      (signal_out),
      .modulated_out   (modulated_out),
      .lfsr_state      (lfsr_state)
   );

   ////////////////////////////////////////////////////////////
   // reference models
   ////////////////////////////////////////////////////////////

   // accumulator and the two register stages after it
   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         acc_model <= '0;
      end
      else
      begin
         acc_model <= acc_model + phase_inc;
      end
      phase_d1 <= acc_model;
      phase_d2 <= phase_d1;
   end

   function automatic sample_t sine_model(input phase_t ph);
      logic [5:0] idx;
      sample_t    mag;
      idx = ph[29:24];
      if (ph[30])
      begin
         idx = 6'd63 - idx;  // second quarter runs backwards
      end
      mag = sample_t'(SINE_QUARTER[idx]);
      if (ph[31])
      begin
         mag = -mag;
      end
      return mag;
   endfunction

   function automatic lfsr_t lfsr_next(input lfsr_t s);
      return {s[3:0], s[4] ^ s[2]};
   endfunction

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
      if (actual !== expected)
      begin
         check_errors++;
         $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_keys(input string name, input key_hold_t expected,
                             input key_hold_t actual);
      if (actual !== expected)
      begin
         check_errors++;
         $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_lfsr(input string name, input lfsr_t expected, input lfsr_t actual);
      if (actual !== expected)
      begin
         check_errors++;
         $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////

   task automatic lfsr_sequence_test();
      lfsr_t expected;
      lfsr_t last;
      int    step;
      int    count;
      @(negedge CLK_25MHZ);
      check_lfsr("lfsr reset", LFSR_SEED, lfsr_state);
      expected = LFSR_SEED;
      for (step = 1; step <= 31; step++)
      begin
         last  = lfsr_state;
         count = 0;
         while (lfsr_state == last && count < WAIT_LIMIT)
         begin
            @(negedge CLK_25MHZ);
            count++;
         end
         if (lfsr_state == last)
         begin
            $display("timeout: lfsr_state did not change within %0d cycles", WAIT_LIMIT);
            timeout_errors++;
            return;
         end
         expected = lfsr_next(expected);
         check_lfsr($sformatf("lfsr step %0d", step), expected, lfsr_state);
      end
      check_lfsr("lfsr period", LFSR_SEED, lfsr_state);  // back at seed after 31
   endtask

   task automatic key_tracking_test();
      logic [KEY_COUNT-1:0] model_bits;
      logic [7:0]           code;
      logic [4:0]           idx;
      int                   n;
      model_bits = '0;
      for (n = 0; n < 120; n++)
      begin
         idx = 5'($urandom_range(16, 0));
         case ($urandom_range(2, 0))
            0:
            begin
               code            = {3'b000, idx};   // make
               model_bits[idx] = 1'b1;
            end
            1:
            begin
               code            = {3'b100, idx};   // break code is index + 128
               model_bits[idx] = 1'b0;
            end
            default:
            begin
               code    = 8'($urandom_range(127, 17));
               code[7] = 1'($urandom_range(1, 0));   // 17..127 or 145..255
            end
         endcase
         @(posedge CLK_25MHZ);
         key_event       <= key_event_e'(code);
         key_event_ready <= 1'b1;
         @(posedge CLK_25MHZ);
         key_event_ready <= 1'b0;
         @(negedge CLK_25MHZ);
         check_keys($sformatf("key event %0d", code), key_hold_t'(model_bits), held_keys);
      end
   endtask

   task automatic sine_cosine_test();
      phase_t inc;
      int     n;
      inc = phase_t'($urandom_range(255, 1)) << 24;
      @(posedge CLK_25MHZ);
      wave_sel  <= WAVE_SIN;
      phase_inc <= inc;
      repeat (3) @(posedge CLK_25MHZ);
      for (n = 0; n < SAMPLE_RUN; n++)
      begin
         @(negedge CLK_25MHZ);
         check_sample("sine", sine_model(phase_d2), signal_out);
      end
      @(posedge CLK_25MHZ);
      wave_sel <= WAVE_COS;
      repeat (2) @(posedge CLK_25MHZ);
      for (n = 0; n < SAMPLE_RUN; n++)
      begin
         @(negedge CLK_25MHZ);
         check_sample("cosine", sine_model(phase_d2 + QUARTER_TURN), signal_out);
      end
   endtask

   task automatic square_saw_test();
      phase_t      inc;
      phase_t      prev_phase;
      sample_t     prev;
      sample_t     step_lo;
      sample_t     step_hi;
      sample_t     diff;
      logic [20:0] low_sum;
      int          n;
      inc     = phase_t'($urandom());
      step_lo = sample_t'(inc[31:20]);
      step_hi = step_lo + 1'b1;   // carry from the low phase bits
      @(posedge CLK_25MHZ);
      wave_sel  <= WAVE_SQU;
      phase_inc <= inc;
      repeat (3) @(posedge CLK_25MHZ);
      for (n = 0; n < SAMPLE_RUN; n++)
      begin
         @(negedge CLK_25MHZ);
         check_sample("square", phase_d2[31] ? -AMPLITUDE : AMPLITUDE, signal_out);
      end
      @(posedge CLK_25MHZ);
      wave_sel <= WAVE_SAW;
      repeat (2) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
      prev       = signal_out;
      prev_phase = phase_d2;
      for (n = 0; n < SAMPLE_RUN; n++)
      begin
         @(negedge CLK_25MHZ);
         check_sample("sawtooth", sample_t'(phase_d2[31:20]), signal_out);
         // low 20 phase bits overflowing add one to the step
         low_sum = {1'b0, prev_phase[19:0]} + {1'b0, inc[19:0]};
         diff    = signal_out - prev;   // wraps mod 4096
         check_sample("sawtooth step", low_sum[20] ? step_hi : step_lo, diff);
         prev       = signal_out;
         prev_phase = phase_d2;
      end
   endtask

   task automatic modulation_test();
      mod_sel_e mode;
      lfsr_t    last;
      sample_t  expected;
      logic     key_bit;
      int       m;
      int       n;
      for (m = 0; m < 4; m++)
      begin
         mode = mod_sel_e'(2'(m));
         @(posedge CLK_25MHZ);
         mod_sel  <= mode;
         wave_sel <= wave_sel_e'(2'(m));
         repeat (2) @(posedge CLK_25MHZ);
         @(negedge CLK_25MHZ);
         last = lfsr_state;
         for (n = 0; n < SAMPLE_RUN; n++)
         begin
            @(negedge CLK_25MHZ);
            if (lfsr_state != last)
            begin
               last = lfsr_state;   // skip the edge where the LFSR moved
               continue;
            end
            key_bit = lfsr_state[0];
            case (mode)
               MOD_ASK:  expected = key_bit ? signal_out : ASK_OFF_LEVEL;
               MOD_BPSK: expected = key_bit ? -signal_out : signal_out;
               MOD_LFSR: expected = key_bit ? LFSR_DISPLAY_LEVEL : '0;
               default:  expected = '0;
            endcase
            check_sample(mode.name(), expected, modulated_out);
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(15767));
      check_errors   = 0;
      timeout_errors = 0;
      key_event       <= KEY_MAKE_DOWN;
      key_event_ready <= 1'b0;
      wave_sel        <= WAVE_SIN;
      mod_sel         <= MOD_NONE;
      phase_inc       <= '0;   // accumulator stays at zero until the sine test
      waited = 0;
      while (reset_from_key !== 1'b0 && waited < WAIT_LIMIT)
      begin
         @(posedge CLK_25MHZ);
         waited++;
      end
      if (reset_from_key !== 1'b0)
      begin
         $display("timeout: reset_from_key never released");
         timeout_errors++;
      end
      else
      begin
         lfsr_sequence_test();
         key_tracking_test();
         sine_cosine_test();
         square_saw_test();
         modulation_test();
      end
      $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
verilog/dds_pkg.sv
verilog/dds_control.sv
verilog/dds_core.sv
verilog/lfsr_gen.sv
verilog/modulator.sv
verilog/dds_lfsr_top.sv
tb/tb_clock_gen.sv
tb/dds_lfsr_assert.sv
tb/dds_lfsr_tb.sv

// File: Makefile
TOP := dds_lfsr_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "test failed" sim.log || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
